// ==== verilog/zombie_pkg.sv ====
package zombie_pkg;

    ////////////////////////////////////////
    // Field sizes
    ////////////////////////////////////////

    // Lanes per row and rows on the track
    localparam int LANES = 3;
    localparam int ROWS  = 5;

    // Track position and counter widths
    localparam int POS_W = 10;
    localparam int CNT_W = 10;

    ////////////////////////////////////////
    // Types
    ////////////////////////////////////////

    typedef logic [POS_W-1:0] pos_t;

    typedef logic [CNT_W-1:0] cnt_t;

    // One bit per lane, 1 means a target is present
    typedef logic [LANES-1:0] lane_mask_t;

    typedef enum logic [1:0] {
        st_idle = 2'd0,
        st_play = 2'd1,
        st_stop = 2'd2
    } game_state_t;

endpackage

// ==== verilog/beat_timer.sv ====
`timescale 1ns/10ps

module beat_timer #(
    parameter int TICK_DIV  = 200000,
    parameter int TRACK_LEN = 480
) (
    input  logic             clk,
    input  logic             rst,
    output logic             tick,
    output zombie_pkg::pos_t phase
);

    localparam int DIV_W = $clog2(TICK_DIV);

    typedef logic [DIV_W-1:0] div_t;

    localparam div_t             DIV_LAST   = div_t'(TICK_DIV - 1);
    localparam zombie_pkg::pos_t PHASE_LAST = zombie_pkg::pos_t'(TRACK_LEN - 1);

    div_t div_cnt;

    ////////////////////////////////////////
    // Scroll tick divider
    ////////////////////////////////////////

    // Tick goes high in the cycle after the counter wraps
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_cnt <= '0;
            tick    <= 1'b0;
        end else begin
            tick <= (div_cnt == DIV_LAST);
            if (div_cnt == DIV_LAST) begin
                div_cnt <= '0;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Track phase
    ////////////////////////////////////////

    // Common time base for all rows
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase <= '0;
        end else if (tick) begin
            if (phase == PHASE_LAST) begin
                phase <= '0;
            end else begin
                phase <= phase + 1'b1;
            end
        end
    end

endmodule

// ==== verilog/zombie_row.sv ====
`timescale 1ns/10ps

module zombie_row #(
    parameter int TRACK_LEN = 480,
    parameter int ROW_GAP   = 96,
    parameter int WINDOW_LO = 384,
    parameter int ROW_INDEX = 0
) (
    input  logic                    clk,
    input  logic                    rst,
    input  zombie_pkg::game_state_t state,
    input  logic                    tick,
    input  zombie_pkg::pos_t        phase,
    input  zombie_pkg::lane_mask_t  pattern,
    input  logic                    no_zombie,
    input  zombie_pkg::lane_mask_t  hit,
    output zombie_pkg::lane_mask_t  lanes,
    output zombie_pkg::lane_mask_t  cleared,
    output zombie_pkg::lane_mask_t  spawned
);

    // One extra bit so phase plus offset cannot overflow
    localparam int SUM_W  = zombie_pkg::POS_W + 1;
    localparam int OFFSET = TRACK_LEN - ROW_INDEX * ROW_GAP;

    typedef logic [SUM_W-1:0] sum_t;

    localparam sum_t             LEN_SUM  = sum_t'(TRACK_LEN);
    localparam sum_t             OFF_SUM  = sum_t'(OFFSET);
    localparam zombie_pkg::pos_t POS_LAST = zombie_pkg::pos_t'(TRACK_LEN - 1);
    localparam zombie_pkg::pos_t POS_WIN  = zombie_pkg::pos_t'(WINDOW_LO);

    sum_t                   pos_sum;
    zombie_pkg::pos_t       pos;
    logic                   play;
    logic                   in_window;
    logic                   spawn_now;
    zombie_pkg::lane_mask_t new_mask;

    ////////////////////////////////////////
    // Row position
    ////////////////////////////////////////

    assign pos_sum = sum_t'(phase) + OFF_SUM;

    // Sum stays below twice the track length, one subtract is enough
    assign pos = (pos_sum >= LEN_SUM) ? zombie_pkg::pos_t'(pos_sum - LEN_SUM)
                                      : zombie_pkg::pos_t'(pos_sum);

    assign in_window = (pos >= POS_WIN);

    ////////////////////////////////////////
    // Spawn and clear decisions
    ////////////////////////////////////////

    assign play = (state == zombie_pkg::st_play);

    // Row wraps to the top on this tick
    assign spawn_now = play && tick && (pos == POS_LAST);

    assign new_mask = no_zombie ? '0 : pattern;

    assign spawned = spawn_now ? new_mask : '0;

    // Only lanes that still hold a target can clear
    assign cleared = (play && !spawn_now && in_window) ? (lanes & hit) : '0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lanes <= '0;
        end else if (!play) begin
            lanes <= '0;
        end else if (spawn_now) begin
            lanes <= new_mask;
        end else begin
            lanes <= lanes & ~cleared;
        end
    end

endmodule

// ==== verilog/score_tally.sv ====
`timescale 1ns/10ps

module score_tally (
    input  logic                                             clk,
    input  logic                                             rst,
    input  zombie_pkg::game_state_t                          state,
    input  logic [zombie_pkg::ROWS*zombie_pkg::LANES-1:0]    cleared,
    input  logic [zombie_pkg::ROWS*zombie_pkg::LANES-1:0]    spawned,
    output zombie_pkg::cnt_t                                 score,
    output zombie_pkg::cnt_t                                 total
);

    localparam int NBITS  = zombie_pkg::ROWS * zombie_pkg::LANES;
    localparam int ONES_W = $clog2(NBITS + 1);

    typedef logic [ONES_W-1:0] ones_t;

    ones_t clr_ones;
    ones_t spw_ones;

    ////////////////////////////////////////
    // Set bit counts
    ////////////////////////////////////////

    function automatic ones_t count_ones(input logic [NBITS-1:0] bits);
        ones_t n;
        n = '0;
        for (int i = 0; i < NBITS; i++) begin
            n = n + ones_t'(bits[i]);
        end
        return n;
    endfunction

    assign clr_ones = count_ones(cleared);
    assign spw_ones = count_ones(spawned);

    ////////////////////////////////////////
    // Accumulators
    ////////////////////////////////////////

    // Rows report nothing outside play, so both hold in stop
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            score <= '0;
        end else if (state == zombie_pkg::st_idle) begin
            score <= '0;
        end else begin
            score <= score + zombie_pkg::cnt_t'(clr_ones);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            total <= '0;
        end else if (state == zombie_pkg::st_idle) begin
            total <= '0;
        end else begin
            total <= total + zombie_pkg::cnt_t'(spw_ones);
        end
    end

endmodule

// ==== verilog/zombie_field.sv ====
`timescale 1ns/10ps

module zombie_field #(
    parameter int TICK_DIV  = 200000,
    parameter int TRACK_LEN = 480,
    parameter int ROW_GAP   = 96,
    parameter int WINDOW_LO = 384
) (
    input  logic                                          clk,
    input  logic                                          rst,
    input  zombie_pkg::game_state_t                       state,
    input  zombie_pkg::lane_mask_t                        pattern,
    input  logic                                          no_zombie,
    input  zombie_pkg::lane_mask_t                        hit,
    output logic [zombie_pkg::ROWS*zombie_pkg::LANES-1:0] zombies,
    output zombie_pkg::cnt_t                              score,
    output zombie_pkg::cnt_t                              total
);

    localparam int LANES = zombie_pkg::LANES;
    localparam int ROWS  = zombie_pkg::ROWS;

    logic                    tick;
    zombie_pkg::pos_t        phase;
    logic [ROWS*LANES-1:0]   cleared_all;
    logic [ROWS*LANES-1:0]   spawned_all;

    ////////////////////////////////////////
    // Time base
    ////////////////////////////////////////

    beat_timer #(
        .TICK_DIV  (TICK_DIV),
        .TRACK_LEN (TRACK_LEN)
    ) u_timer (
        .clk   (clk),
        .rst   (rst),
        .tick  (tick),
        .phase (phase)
    );

    ////////////////////////////////////////
    // Rows
    ////////////////////////////////////////

    // Row r sits in bits r*LANES upward
    for (genvar r = 0; r < ROWS; r++) begin : g_row
        zombie_row #(
            .TRACK_LEN (TRACK_LEN),
            .ROW_GAP   (ROW_GAP),
            .WINDOW_LO (WINDOW_LO),
            .ROW_INDEX (r)
        ) u_row (
            .clk       (clk),
            .rst       (rst),
            .state     (state),
            .tick      (tick),
            .phase     (phase),
            .pattern   (pattern),
            .no_zombie (no_zombie),
            .hit       (hit),
            .lanes     (zombies[r*LANES +: LANES]),
            .cleared   (cleared_all[r*LANES +: LANES]),
            .spawned   (spawned_all[r*LANES +: LANES])
        );
    end

    score_tally u_tally (
        .clk     (clk),
        .rst     (rst),
        .state   (state),
        .cleared (cleared_all),
        .spawned (spawned_all),
        .score   (score),
        .total   (total)
    );

endmodule

// ==== dv/zombie_checker.sv ====
`timescale 1ns/10ps

module zombie_checker #(
    parameter int TICK_DIV  = 2,
    parameter int TRACK_LEN = 40,
    parameter int ROW_GAP   = 8,
    parameter int WINDOW_LO = 32
) (
    input  logic                                          clk,
    input  logic                                          rst,
    input  zombie_pkg::game_state_t                       state,
    input  zombie_pkg::lane_mask_t                        pattern,
    input  logic                                          no_zombie,
    input  zombie_pkg::lane_mask_t                        hit,
    input  logic [zombie_pkg::ROWS*zombie_pkg::LANES-1:0] zombies,
    input  zombie_pkg::cnt_t                              score,
    input  zombie_pkg::cnt_t                              total,
    input  logic [127:0]                                  test_name,
    output int                                            zombie_errs,
    output int                                            score_errs,
    output int                                            total_errs
);

    localparam int LANES = zombie_pkg::LANES;
    localparam int ROWS  = zombie_pkg::ROWS;

    int                     edges;
    int                     phase_m;
    zombie_pkg::lane_mask_t lanes_m [ROWS];
    zombie_pkg::cnt_t       score_m;
    zombie_pkg::cnt_t       total_m;
    logic [127:0]           name_q;
    int                     z_errs = 0;
    int                     s_errs = 0;
    int                     t_errs = 0;

    assign zombie_errs = z_errs;
    assign score_errs  = s_errs;
    assign total_errs  = t_errs;

    function automatic int count_bits(input zombie_pkg::lane_mask_t m);
        int n;
        n = 0;
        for (int i = 0; i < LANES; i++) begin
            n = n + int'(m[i]);
        end
        return n;
    endfunction

    ////////////////////////////////////////
    // Rule model
    ////////////////////////////////////////

    // First tick TICK_DIV edges after reset, then every TICK_DIV
    always @(posedge clk or posedge rst) begin : model_step
        int   pos;
        int   clr_n;
        int   spw_n;
        logic tick_m;
        // Entry whose inputs this edge uses
        name_q = test_name;
        if (rst) begin
            edges   = 0;
            phase_m = 0;
            score_m = '0;
            total_m = '0;
            for (int r = 0; r < ROWS; r++) begin
                lanes_m[r] = '0;
            end
        end else begin
            tick_m = (edges > 0) && (edges % TICK_DIV == 0);
            clr_n  = 0;
            spw_n  = 0;
            for (int r = 0; r < ROWS; r++) begin
                pos = (phase_m + TRACK_LEN - r * ROW_GAP) % TRACK_LEN;
                if (state != zombie_pkg::st_play) begin
                    lanes_m[r] = '0;
                end else if (tick_m && pos == TRACK_LEN - 1) begin
                    lanes_m[r] = no_zombie ? '0 : pattern;
                    spw_n = spw_n + count_bits(lanes_m[r]);
                end else if (pos >= WINDOW_LO) begin
                    clr_n = clr_n + count_bits(lanes_m[r] & hit);
                    lanes_m[r] = lanes_m[r] & ~hit;
                end
            end
            if (state == zombie_pkg::st_idle) begin
                score_m = '0;
                total_m = '0;
            end else begin
                score_m = score_m + zombie_pkg::cnt_t'(clr_n);
                total_m = total_m + zombie_pkg::cnt_t'(spw_n);
            end
            if (tick_m) begin
                phase_m = (phase_m + 1) % TRACK_LEN;
            end
            edges = edges + 1;
        end
    end

    ////////////////////////////////////////
    // Compare on the falling edge
    ////////////////////////////////////////

    always @(negedge clk) begin : compare
        logic [ROWS*LANES-1:0] exp_z;
        for (int r = 0; r < ROWS; r++) begin
            exp_z[r*LANES +: LANES] = lanes_m[r];
        end
        if (zombies !== exp_z) begin
            z_errs = z_errs + 1;
            $display("Fail %0s: zombies expected %h actual %h", name_q, exp_z, zombies);
        end
        if (score !== score_m) begin
            s_errs = s_errs + 1;
            $display("Fail %0s: score expected %0d actual %0d", name_q, score_m, score);
        end
        if (total !== total_m) begin
            t_errs = t_errs + 1;
            $display("Fail %0s: total expected %0d actual %0d", name_q, total_m, total);
        end
    end

endmodule

// ==== dv/zombie_field_tb.sv ====
`timescale 1ns/10ps

module zombie_field_tb;

    localparam int TICK_DIV   = 2;
    localparam int TRACK_LEN  = 40;
    localparam int ROW_GAP    = 8;
    localparam int WINDOW_LO  = 32;
    localparam int CLK_PERIOD = 40;
    localparam int N_TESTS    = 9;
    localparam int LANES      = zombie_pkg::LANES;
    localparam int ROWS       = zombie_pkg::ROWS;

    // Hit modes
    localparam int HIT_OFF  = 0;
    localparam int HIT_HELD = 1;
    localparam int HIT_RAND = 2;

    logic                          clk = 1'b0;
    logic                          rst;
    zombie_pkg::game_state_t       state;
    zombie_pkg::lane_mask_t        pattern;
    logic                          no_zombie;
    zombie_pkg::lane_mask_t        hit;
    logic [ROWS*LANES-1:0]         zombies;
    zombie_pkg::cnt_t              score;
    zombie_pkg::cnt_t              total;
    logic [127:0]                  test_name;
    int                            zombie_errs;
    int                            score_errs;
    int                            total_errs;

    logic [31:0]                   lfsr;
    logic                          table_ready;
    int                            wd_cycles;

    // Stimulus table
    logic [127:0]                  names  [N_TESTS];
    zombie_pkg::game_state_t       states [N_TESTS];
    zombie_pkg::lane_mask_t        pats   [N_TESTS];
    logic                          nzs    [N_TESTS];
    int                            modes  [N_TESTS];
    int                            lens   [N_TESTS];

    zombie_field #(
        .TICK_DIV  (TICK_DIV),
        .TRACK_LEN (TRACK_LEN),
        .ROW_GAP   (ROW_GAP),
        .WINDOW_LO (WINDOW_LO)
    ) uut (
        .clk       (clk),
        .rst       (rst),
        .state     (state),
        .pattern   (pattern),
        .no_zombie (no_zombie),
        .hit       (hit),
        .zombies   (zombies),
        .score     (score),
        .total     (total)
    );

    zombie_checker #(
        .TICK_DIV  (TICK_DIV),
        .TRACK_LEN (TRACK_LEN),
        .ROW_GAP   (ROW_GAP),
        .WINDOW_LO (WINDOW_LO)
    ) checker_i (
        .clk         (clk),
        .rst         (rst),
        .state       (state),
        .pattern     (pattern),
        .no_zombie   (no_zombie),
        .hit         (hit),
        .zombies     (zombies),
        .score       (score),
        .total       (total),
        .test_name   (test_name),
        .zombie_errs (zombie_errs),
        .score_errs  (score_errs),
        .total_errs  (total_errs)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////
    // Random button bits
    ////////////////////////////////////////

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic draw_hit(output zombie_pkg::lane_mask_t m);
        for (int i = 0; i < LANES; i++) begin
            lfsr = lfsr_next(lfsr);
            m[i] = lfsr[0];
        end
    endtask

    task automatic add_test(input int idx, input logic [127:0] name,
                            input zombie_pkg::game_state_t st,
                            input zombie_pkg::lane_mask_t pat, input logic nz,
                            input int mode, input int len);
        names[idx]  = name;
        states[idx] = st;
        pats[idx]   = pat;
        nzs[idx]    = nz;
        modes[idx]  = mode;
        lens[idx]   = len;
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        zombie_pkg::lane_mask_t next_hit;
        rst         = 1'b1;
        state       = zombie_pkg::st_idle;
        pattern     = '0;
        no_zombie   = 1'b0;
        hit         = '0;
        test_name   = "reset";
        lfsr        = 32'h1bf5eda1;
        table_ready = 1'b0;

        add_test(0, "reset_idle",   zombie_pkg::st_idle, 3'b000, 1'b0, HIT_OFF,  10);
        add_test(1, "spawn_fixed",  zombie_pkg::st_play, 3'b101, 1'b0, HIT_OFF,  100);
        add_test(2, "no_zombie",    zombie_pkg::st_play, 3'b111, 1'b1, HIT_OFF,  90);
        add_test(3, "spawn_all",    zombie_pkg::st_play, 3'b111, 1'b0, HIT_OFF,  90);
        add_test(4, "held_hits",    zombie_pkg::st_play, 3'b111, 1'b0, HIT_HELD, 90);
        add_test(5, "random_hits",  zombie_pkg::st_play, 3'b111, 1'b0, HIT_RAND, 200);
        add_test(6, "random_mixed", zombie_pkg::st_play, 3'b011, 1'b0, HIT_RAND, 120);
        add_test(7, "stop_hold",    zombie_pkg::st_stop, 3'b111, 1'b0, HIT_RAND, 30);
        add_test(8, "idle_clear",   zombie_pkg::st_idle, 3'b000, 1'b0, HIT_OFF,  20);

        wd_cycles = 50;
        for (int i = 0; i < N_TESTS; i++) begin
            wd_cycles = wd_cycles + lens[i];
        end
        table_ready = 1'b1;

        repeat (5) @(posedge clk);
        rst <= 1'b0;

        for (int t = 0; t < N_TESTS; t++) begin
            for (int c = 0; c < lens[t]; c++) begin
                @(posedge clk);
                next_hit = '0;
                if (modes[t] == HIT_HELD) begin
                    next_hit = '1;
                end else if (modes[t] == HIT_RAND) begin
                    draw_hit(next_hit);
                end
                test_name <= names[t];
                state     <= states[t];
                pattern   <= pats[t];
                no_zombie <= nzs[t];
                hit       <= next_hit;
            end
        end

        // Let the last applied cycle be checked
        repeat (2) @(posedge clk);
        $display("Errors: zombies %0d, score %0d, total %0d",
                 zombie_errs, score_errs, total_errs);
        if (zombie_errs + score_errs + total_errs == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        wait (table_ready);
        #(wd_cycles * CLK_PERIOD);
        $display("Timeout: the tests did not finish within %0d cycles", wd_cycles);
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== vlog.f ====
verilog/zombie_pkg.sv
verilog/beat_timer.sv
verilog/zombie_row.sv
verilog/score_tally.sv
verilog/zombie_field.sv
dv/zombie_checker.sv
dv/zombie_field_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing -f vlog.f --top-module zombie_field_tb -o zombie_sim

./obj_dir/zombie_sim | tee sim.log

if grep -q "Simulation failed" sim.log; then
    echo "Run reported a failure, see sim.log"
    exit 1
fi

echo "Run finished without a reported failure"
exit 0
